/* hdl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_pkg::dec_t  dec,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    output rv_pkg::word_t alu_result
);
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    logic [4:0]    shamt;

    assign op_a  = dec.use_pc ? pc : rs1_data;  // AUIPC
    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_ADD: begin
                alu_result = op_a + op_b;
            end
            rv_pkg::ALU_SUB: begin
                alu_result = op_a - op_b;
            end
            rv_pkg::ALU_SLL: begin
                alu_result = op_a << shamt;
            end
            rv_pkg::ALU_SLT: begin
                alu_result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            end
            rv_pkg::ALU_SLTU: begin
                alu_result = rv_pkg::word_t'(op_a < op_b);
            end
            rv_pkg::ALU_XOR: begin
                alu_result = op_a ^ op_b;
            end
            rv_pkg::ALU_SRL: begin
                alu_result = op_a >> shamt;
            end
            rv_pkg::ALU_SRA: begin
                alu_result = rv_pkg::word_t'($signed(op_a) >>> shamt);
            end
            rv_pkg::ALU_OR: begin
                alu_result = op_a | op_b;
            end
            rv_pkg::ALU_AND: begin
                alu_result = op_a & op_b;
            end
            rv_pkg::ALU_PASS_IMM: begin
                alu_result = dec.imm;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_branch_unit (
    input  rv_pkg::dec_t  dec,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    output logic          redirect,
    output rv_pkg::word_t target
);
    logic          taken;
    rv_pkg::word_t base;
    rv_pkg::word_t sum;

    always_comb begin
        case (dec.branch_type)
            3'b000:  taken = (rs1_data == rs2_data);                    // BEQ
            3'b001:  taken = (rs1_data != rs2_data);                    // BNE
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));   // BLT
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));  // BGE
            3'b110:  taken = (rs1_data < rs2_data);                     // BLTU
            3'b111:  taken = (rs1_data >= rs2_data);                    // BGEU
            default: taken = 1'b0;
        endcase
    end

    assign base = dec.is_jalr ? rs1_data : pc;
    assign sum  = base + dec.imm;

    // JALR drops bit 0 of its target
    assign target = dec.is_jalr ? {sum[rv_pkg::xlen-1:1], 1'b0} : sum;

    assign redirect = dec.is_jal || dec.is_jalr || (dec.is_branch && taken);

endmodule

`default_nettype wire

/* hdl/rv_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_commit #(
    parameter rv_pkg::word_t RESET_PC = rv_pkg::RESET_PC_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::dec_t    dec,
    input  logic            inst_valid,
    input  rv_pkg::word_t   alu_result,
    input  logic            redirect,
    input  rv_pkg::word_t   target,
    output rv_pkg::word_t   pc,
    output logic            halted,
    output logic            rf_wen,
    output rv_pkg::word_t   rf_wdata,
    output rv_pkg::retire_t retire
);
    rv_pkg::word_t pc_plus4;
    rv_pkg::word_t next_pc;
    logic          fire;

    assign fire     = inst_valid && !halted;  // Instruction executes this cycle
    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = redirect ? target : pc_plus4;

    assign rf_wen   = fire && dec.rd_wen;
    assign rf_wdata = (dec.is_jal || dec.is_jalr) ? pc_plus4 : alu_result;  // Link value

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else if (fire) begin
            pc <= next_pc;
            if (dec.is_ebreak) begin
                halted <= 1'b1;  // Sticky until reset
            end
        end
    end

    assign retire.valid   = fire;
    assign retire.pc      = pc;
    assign retire.rd_wen  = rf_wen;
    assign retire.rd_addr = dec.rd_addr;
    assign retire.rd_data = rf_wdata;

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = rv_pkg::RESET_PC_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    output rv_pkg::word_t   inst_addr,
    input  rv_pkg::word_t   inst_data,
    input  logic            inst_valid,
    output logic            halted,
    output rv_pkg::retire_t retire
);
    rv_pkg::dec_t  dec;
    rv_pkg::word_t rs1_data;
    rv_pkg::word_t rs2_data;
    rv_pkg::word_t alu_result;
    rv_pkg::word_t target;
    rv_pkg::word_t rf_wdata;
    logic          redirect;
    logic          rf_wen;

    rv_decoder u_decoder (
        .inst (inst_data),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (dec.rs1_addr),
        .rs2_addr (dec.rs2_addr),
        .wen      (rf_wen),
        .waddr    (dec.rd_addr),
        .wdata    (rf_wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .dec        (dec),
        .pc         (inst_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result)
    );

    rv_branch_unit u_branch_unit (
        .dec      (dec),
        .pc       (inst_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .redirect (redirect),
        .target   (target)
    );

    rv_commit #(
        .RESET_PC (RESET_PC)
    ) u_commit (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .inst_valid (inst_valid),
        .alu_result (alu_result),
        .redirect   (redirect),
        .target     (target),
        .pc         (inst_addr),  // PC drives the fetch address
        .halted     (halted),
        .rf_wen     (rf_wen),
        .rf_wdata   (rf_wdata),
        .retire     (retire)
    );

endmodule

`default_nettype wire

/* hdl/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  rv_pkg::word_t inst,
    output rv_pkg::dec_t  dec
);
    localparam rv_pkg::word_t EBREAK_WORD = 32'h0010_0073;

    rv_pkg::opcode_t opcode;
    rv_pkg::funct3_t funct3;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_j;
    rv_pkg::alu_op_e arith_op;
    logic            writes_rd;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // Shared by OP and OP-IMM, bit 30 picks SUB and SRA
    always_comb begin
        case (funct3)
            3'b000: begin
                if (opcode == rv_pkg::OPC_OP && inst[30]) begin
                    arith_op = rv_pkg::ALU_SUB;
                end else begin
                    arith_op = rv_pkg::ALU_ADD;  // ADDI never subtracts
                end
            end
            3'b001:  arith_op = rv_pkg::ALU_SLL;
            3'b010:  arith_op = rv_pkg::ALU_SLT;
            3'b011:  arith_op = rv_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_pkg::ALU_XOR;
            3'b101: begin
                if (inst[30]) begin
                    arith_op = rv_pkg::ALU_SRA;
                end else begin
                    arith_op = rv_pkg::ALU_SRL;
                end
            end
            3'b110:  arith_op = rv_pkg::ALU_OR;
            default: arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        dec             = '0;
        dec.rs1_addr    = inst[19:15];
        dec.rs2_addr    = inst[24:20];
        dec.rd_addr     = inst[11:7];
        dec.branch_type = funct3;
        dec.alu_op      = rv_pkg::ALU_ADD;
        writes_rd       = 1'b0;

        case (opcode)
            rv_pkg::OPC_LUI: begin
                dec.imm     = imm_u;
                dec.alu_op  = rv_pkg::ALU_PASS_IMM;
                dec.use_imm = 1'b1;
                writes_rd   = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                dec.imm     = imm_u;
                dec.use_imm = 1'b1;
                dec.use_pc  = 1'b1;
                writes_rd   = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                dec.imm    = imm_j;
                dec.is_jal = 1'b1;
                writes_rd  = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                dec.imm     = imm_i;
                dec.use_imm = 1'b1;
                dec.is_jalr = 1'b1;
                writes_rd   = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                dec.imm     = imm_i;
                dec.alu_op  = arith_op;
                dec.use_imm = 1'b1;
                writes_rd   = 1'b1;
            end
            rv_pkg::OPC_OP: begin
                dec.alu_op = arith_op;
                writes_rd  = 1'b1;
            end
            rv_pkg::OPC_SYSTEM: begin
                dec.is_ebreak = (inst == EBREAK_WORD);
            end
            default: begin
                writes_rd = 1'b0;  // Unsupported opcodes act as no-ops
            end
        endcase

        dec.rd_wen = writes_rd && (dec.rd_addr != '0);
    end

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;

    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD      = 4'b0000,
        ALU_SUB      = 4'b0001,
        ALU_SLL      = 4'b0010,
        ALU_SLT      = 4'b0011,
        ALU_SLTU     = 4'b0100,
        ALU_XOR      = 4'b0101,
        ALU_SRL      = 4'b0110,
        ALU_SRA      = 4'b0111,
        ALU_OR       = 4'b1000,
        ALU_AND      = 4'b1001,
        ALU_PASS_IMM = 4'b1010  // LUI
    } alu_op_e;

    typedef struct packed {
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        word_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;     // Operand B from imm
        logic      use_pc;      // Operand A from PC
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        funct3_t   branch_type;
        logic      rd_wen;      // Already excludes x0
        logic      is_ebreak;
    } dec_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      rd_wen;
        reg_addr_t rd_addr;
        word_t     rd_data;
    } retire_t;

    localparam word_t RESET_PC_DEFAULT = 32'h8000_0000;

endpackage

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  logic              wen,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    rv_pkg::word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;  // wen is never set for x0
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* rv_core.f */
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_branch_unit.sv
hdl/rv_commit.sv
hdl/rv_core.sv
testbench/tb_clock.sv
testbench/tb_rv_core.sv

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;  // Released just after the edge
    end

endmodule

`default_nettype wire

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    typedef rv_pkg::word_t     word_t;
    typedef rv_pkg::reg_addr_t reg_t;

    localparam int max_cycles = 2000;  // Tests need under a hundred cycles

    logic            clk;
    logic            reset;
    logic            inst_valid;
    logic            halted;
    word_t           inst_addr;
    word_t           inst_data;
    rv_pkg::retire_t retire;

    word_t imem [0:1023];
    word_t shadow [0:31];  // Expected register contents
    word_t pc_model;
    word_t rng_state = 32'd70;
    int    cycles = 0;

    tb_clock clock_gen (.clk(clk), .reset(reset));

    rv_core dut (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_addr),
        .inst_data  (inst_data),
        .inst_valid (inst_valid),
        .halted     (halted),
        .retire     (retire)
    );

    assign inst_data = imem[inst_addr[11:2]];  // Aliases every 4 KiB

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: no result after %0d cycles", max_cycles);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    function automatic word_t r_type(input logic [6:0] f7, input reg_t rs2, input reg_t rs1,
                                     input logic [2:0] f3, input reg_t rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_t rs1,
                                     input logic [2:0] f3, input reg_t rd,
                                     input rv_pkg::opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_t rd,
                                     input rv_pkg::opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t b_type(input logic [12:0] off, input reg_t rs2, input reg_t rs1,
                                     input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input reg_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    function automatic word_t xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        logic signed [31:0] sa;
        logic [4:0]         sh;
        sa = a;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return (sa < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'(sa >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic compare(input string test, input string what,
                           input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Error %s %s: expected %h actual %h", test, what, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // One instruction at the model PC, checked before and after its edge
    task automatic execute(input string name, input word_t inst, input logic writes,
                           input word_t exp_data, input word_t exp_next);
        reg_t rd;
        logic exp_wen;
        rd      = inst[11:7];
        exp_wen = writes && (rd != 5'd0);
        imem[pc_model[11:2]] = inst;
        inst_valid = 1'b1;
        #2;
        compare(name, "retire valid", 1'b1, retire.valid);
        compare(name, "retire pc", pc_model, retire.pc);
        compare(name, "rd_wen", exp_wen, retire.rd_wen);
        if (exp_wen) begin
            compare(name, "rd_addr", rd, retire.rd_addr);
            compare(name, "rd_data", exp_data, retire.rd_data);
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        compare(name, "next inst_addr", exp_next, inst_addr);
        if (exp_wen) begin
            shadow[rd] = exp_data;
        end
        pc_model = exp_next;
    endtask

    task automatic load_constant(input reg_t rd, input word_t value);
        logic [19:0] hi;
        hi = value[31:12] + value[11];  // ADDI sign-extends
        execute("lui", u_type(hi, rd, rv_pkg::OPC_LUI), 1'b1, {hi, 12'b0}, pc_model + 4);
        execute("addi", i_type(value[11:0], rd, 3'b000, rd, rv_pkg::OPC_OP_IMM), 1'b1, value,
                pc_model + 4);
    endtask

    task automatic hold_checks(input string name, input int n);
        repeat (n) begin
            #2;
            compare(name, "retire valid", 1'b0, retire.valid);
            compare(name, "rd_wen", 1'b0, retire.rd_wen);
            @(posedge clk);
            #1;
            compare(name, "inst_addr", pc_model, inst_addr);
        end
    endtask

    task automatic reset_values();
        #2;
        compare("reset", "inst_addr", rv_pkg::RESET_PC_DEFAULT, inst_addr);
        compare("reset", "halted", 1'b0, halted);
        compare("reset", "retire valid", 1'b0, retire.valid);
        @(posedge clk);
        #1;
        compare("reset", "idle inst_addr", rv_pkg::RESET_PC_DEFAULT, inst_addr);
    endtask

    task automatic alu_operations();
        word_t       rnd;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        reg_t        rd;
        int          k;
        load_constant(5'd1, xorshift32());
        load_constant(5'd2, xorshift32());
        for (k = 0; k < 10; k++) begin
            f3  = (k < 8) ? k[2:0] : ((k == 8) ? 3'd0 : 3'd5);
            alt = (k >= 8);  // SUB and SRA
            rd  = 5'd3 + k[4:0];
            execute($sformatf("alu_r op %0d", k), r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, rd),
                    1'b1, alu_model(f3, alt, shadow[1], shadow[2]), pc_model + 4);
            if (k != 8) begin
                rnd = xorshift32();
                imm = (f3 == 3'd1 || f3 == 3'd5) ? {alt ? 7'h20 : 7'h00, rnd[4:0]} : rnd[11:0];
                execute($sformatf("alu_i op %0d", k),
                        i_type(imm, 5'd1, f3, rd + 5'd10, rv_pkg::OPC_OP_IMM), 1'b1,
                        alu_model(f3, alt, shadow[1], {{20{imm[11]}}, imm}), pc_model + 4);
            end
        end
        rnd = xorshift32();
        execute("auipc", u_type(rnd[31:12], 5'd23, rv_pkg::OPC_AUIPC), 1'b1,
                pc_model + {rnd[31:12], 12'b0}, pc_model + 4);
    endtask

    task automatic zero_register();
        execute("x0 write", i_type(12'h005, 5'd1, 3'b000, 5'd0, rv_pkg::OPC_OP_IMM), 1'b1,
                shadow[1] + 32'd5, pc_model + 4);
        execute("x0 rs1", r_type(7'h00, 5'd2, 5'd0, 3'b000, 5'd24), 1'b1, shadow[2], pc_model + 4);
        execute("x0 rs2", r_type(7'h00, 5'd0, 5'd2, 3'b000, 5'd25), 1'b1, shadow[2], pc_model + 4);
    endtask

    task automatic control_flow();
        reg_t        rs1;
        reg_t        rs2;
        logic [2:0]  f3;
        logic [12:0] off;
        int          b;
        int          p;
        load_constant(5'd1, 32'h8000_0010);  // Negative signed, large unsigned
        load_constant(5'd2, 32'd5);
        for (b = 0; b < 6; b++) begin
            f3 = (b < 2) ? b[2:0] : b[2:0] + 3'd2;
            for (p = 0; p < 3; p++) begin
                rs1 = (p == 1) ? 5'd2 : 5'd1;
                rs2 = (p == 0) ? 5'd2 : 5'd1;
                off = (p == 1) ? 13'h1ff4 : 13'd16;  // -12 or +16
                execute($sformatf("branch f3 %0d pair %0d", f3, p), b_type(off, rs2, rs1, f3),
                        1'b0, 32'd0, branch_model(f3, shadow[rs1], shadow[rs2]) ?
                        pc_model + {{19{off[12]}}, off} : pc_model + 4);
            end
        end
        execute("jal forward", j_type(21'd20, 5'd3), 1'b1, pc_model + 4, pc_model + 32'd20);
        execute("jal backward", j_type(21'h1ffff8, 5'd4), 1'b1, pc_model + 4, pc_model - 32'd8);
        load_constant(5'd8, rv_pkg::RESET_PC_DEFAULT + 32'h201);  // Odd base
        execute("jalr odd", i_type(12'h000, 5'd8, 3'b000, 5'd9, rv_pkg::OPC_JALR), 1'b1,
                pc_model + 4, shadow[8] & ~32'd1);
        execute("jalr imm", i_type(12'hff8, 5'd8, 3'b000, 5'd10, rv_pkg::OPC_JALR), 1'b1,
                pc_model + 4, (shadow[8] - 32'd8) & ~32'd1);
    endtask

    task automatic stall_cycles();
        word_t inst;
        inst = i_type(12'd123, 5'd0, 3'b000, 5'd11, rv_pkg::OPC_OP_IMM);
        imem[pc_model[11:2]] = inst;  // Present but not valid
        inst_valid = 1'b0;
        hold_checks("stall", 5);
        execute("stall resume", inst, 1'b1, 32'd123, pc_model + 4);
        execute("stall add", r_type(7'h00, 5'd11, 5'd11, 3'b000, 5'd12), 1'b1, 32'd246,
                pc_model + 4);
    endtask

    task automatic halt_on_ebreak();
        compare("halt", "halted before", 1'b0, halted);
        execute("ebreak", i_type(12'h001, 5'd0, 3'b000, 5'd0, rv_pkg::OPC_SYSTEM), 1'b0, 32'd0,
                pc_model + 4);
        compare("halt", "halted", 1'b1, halted);
        imem[pc_model[11:2]] = i_type(12'd1, 5'd0, 3'b000, 5'd14, rv_pkg::OPC_OP_IMM);
        inst_valid = 1'b1;
        hold_checks("halted", 4);
        compare("halt", "still halted", 1'b1, halted);
        inst_valid = 1'b0;
    endtask

    initial begin
        int i;
        inst_valid = 1'b0;
        pc_model   = rv_pkg::RESET_PC_DEFAULT;
        for (i = 0; i < 1024; i++) begin
            imem[i] = i_type(i[11:0], 5'd0, 3'b000, 5'd0, rv_pkg::OPC_OP_IMM);  // Tagged NOP
        end
        for (i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        @(negedge reset);
        reset_values();
        alu_operations();
        zero_register();
        control_flow();
        stall_cycles();
        halt_on_ebreak();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
